// ==== Bender.yml ====
package:
  name: riscv_bpu

sources:
  - files:
      - hdl/bpu_pkg.sv
      - hdl/pred_table.sv
      - hdl/tage_predictor.sv
      - hdl/btb.sv
      - hdl/return_stack.sv
      - hdl/next_pc_select.sv
      - hdl/bpu_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/bpu_assertions.sv
      - sim/tb_bpu.sv

// ==== flist.f ====
hdl/bpu_pkg.sv
hdl/pred_table.sv
hdl/tage_predictor.sv
hdl/btb.sv
hdl/return_stack.sv
hdl/next_pc_select.sv
hdl/bpu_top.sv
sim/tb_clock.sv
sim/bpu_assertions.sv
sim/tb_bpu.sv

// ==== hdl/bpu_pkg.sv ====
package bpu_pkg;

    localparam int XLEN             = 32;
    localparam int HIST_W           = 16;

    localparam int BIMODAL_ENTRIES  = 512;
    localparam int BIMODAL_IDX_W    = $clog2(BIMODAL_ENTRIES);
    localparam int TAGGED_ENTRIES   = 256;
    localparam int TAGGED_IDX_W     = $clog2(TAGGED_ENTRIES);
    localparam int TAG_W            = 10;
    localparam int PARTIAL_TAG_BITS = 6;   // upper tag bits used for a hit

    localparam int BTB_ENTRIES      = 256;
    localparam int BTB_IDX_W        = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W        = 22;

    localparam int RAS_DEPTH        = 64;
    localparam int RAS_IDX_W        = $clog2(RAS_DEPTH);
    localparam int RAS_PTR_W        = 7;   // holds 0..RAS_DEPTH

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef logic [1:0] ctr_t;   // 2-bit saturating counter, msb is the direction
    localparam ctr_t CTR_WEAK_NT = 2'd1;

    typedef enum logic [1:0] {
        PROV_BIMODAL,
        PROV_T0,
        PROV_T1
    } provider_e;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        ctr_t             ctr;
    } tagged_entry_t;

    localparam tagged_entry_t TAGGED_RESET = '{tag: '0, ctr: CTR_WEAK_NT};

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    // resolved branch coming back from execute
    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              pred_correct;
        logic [XLEN-1:0]   pc;
        logic [HIST_W-1:0] history;   // history seen at prediction time
        provider_e         provider;
        logic [XLEN-1:0]   target;
        logic [XLEN-1:0]   inst;
    } ex_feedback_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } ras_push_t;

    typedef struct packed {
        logic            is_ctrl;
        logic            taken;
        logic [XLEN-1:0] target;
        provider_e       provider;
    } prediction_t;

    // jalr x0, 0(x1) or jalr x0, 0(x5)
    function automatic logic is_return(input logic [XLEN-1:0] inst);
        return (inst[6:0] == OPC_JALR) && (inst[11:7] == 5'd0) &&
               ((inst[19:15] == 5'd1) || (inst[19:15] == 5'd5)) &&
               (inst[31:20] == 12'd0);
    endfunction

endpackage

// ==== hdl/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]   if_inst_i,
    input  bpu_pkg::ex_feedback_t      ex_fb_i,
    input  bpu_pkg::ras_push_t         id_push_i,
    input  logic                       ex_stall_i,
    input  logic                       id_stall_i,
    output bpu_pkg::prediction_t       pred_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    logic            tage_taken;
    provider_e       tage_provider;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_top;
    logic            ras_empty;

    tage_predictor u_tage (
        .clk, .rst, .if_pc_i, .fb_i(ex_fb_i),
        .taken_o(tage_taken), .provider_o(tage_provider), .history_o
    );

    btb u_btb (
        .clk, .rst, .if_pc_i, .fb_i(ex_fb_i),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    return_stack u_ras (
        .clk, .rst, .fb_i(ex_fb_i), .push_i(id_push_i),
        .ex_stall_i, .id_stall_i, .top_o(ras_top), .empty_o(ras_empty)
    );

    // final target mux, purely combinational
    next_pc_select u_sel (
        .if_pc_i, .if_inst_i,
        .tage_taken_i(tage_taken), .provider_i(tage_provider),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_top_i(ras_top), .ras_empty_i(ras_empty),
        .push_i(id_push_i), .pred_o
    );

endmodule

// ==== hdl/btb.sv ====
`timescale 1ns/1ps

module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  bpu_pkg::ex_feedback_t    fb_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o
);
    import bpu_pkg::*;

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_TAG_W-1:0] if_tag;
    btb_entry_t           rd_entry;
    btb_entry_t           wr_entry;
    logic                 fill;

    // word aligned pc, low bits skipped
    assign rd_idx = if_pc_i[BTB_IDX_W+1:2];
    assign if_tag = if_pc_i[XLEN-1 -: BTB_TAG_W];
    assign wr_idx = fb_i.pc[BTB_IDX_W+1:2];

    assign fill     = fb_i.valid && fb_i.taken;   // only taken branches fill
    assign wr_entry = '{valid: 1'b1, tag: fb_i.pc[XLEN-1 -: BTB_TAG_W], target: fb_i.target};

    pred_table #(
        .entry_t  (btb_entry_t),
        .ENTRIES  (BTB_ENTRIES),
        .RD_PORTS (1),
        .RESET_VAL('0)
    ) u_table (
        .clk,
        .rst,
        .rd_idx_i (rd_idx),
        .rd_data_o(rd_entry),
        .wr_en_i  (fill),
        .wr_idx_i (wr_idx),
        .wr_data_i(wr_entry)
    );

    assign hit_o    = rd_entry.valid && (rd_entry.tag == if_tag);
    assign target_o = rd_entry.target;

endmodule

// ==== hdl/next_pc_select.sv ====
`timescale 1ns/1ps

module next_pc_select (
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] if_inst_i,
    input  logic                     tage_taken_i,
    input  bpu_pkg::provider_e       provider_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_top_i,
    input  logic                     ras_empty_i,
    input  bpu_pkg::ras_push_t       push_i,
    output bpu_pkg::prediction_t     pred_o
);
    import bpu_pkg::*;

    logic [6:0]      opcode;
    logic            is_br;
    logic            is_jal;
    logic            is_jalr;
    logic            is_ret;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] pc_plus4;

    assign opcode  = if_inst_i[6:0];
    assign is_br   = (opcode == OPC_BRANCH);
    assign is_jal  = (opcode == OPC_JAL);
    assign is_jalr = (opcode == OPC_JALR);
    assign is_ret  = is_return(if_inst_i);

    // sign extended immediates
    assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    assign pc_plus4 = if_pc_i + 32'd4;

    always_comb begin
        pred_o.is_ctrl  = is_br || is_jal || is_jalr;
        pred_o.taken    = 1'b0;
        pred_o.target   = pc_plus4;
        pred_o.provider = provider_i;   // passed on for every type

        if (is_jal) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit_i ? btb_target_i : if_pc_i + imm_j;
        end else if (is_ret) begin
            // a call decoded this cycle is not on the stack yet
            if (push_i.valid) begin
                pred_o.taken  = 1'b1;
                pred_o.target = push_i.addr;
            end else if (!ras_empty_i) begin
                pred_o.taken  = 1'b1;
                pred_o.target = ras_top_i;
            end
        end else if (is_br && tage_taken_i) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit_i ? btb_target_i : if_pc_i + imm_b;
        end
        // other jalr stays not taken, target unknown here
    end

endmodule

// ==== hdl/pred_table.sv ====
`timescale 1ns/1ps

module pred_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     ENTRIES   = 256,
    parameter int     RD_PORTS  = 1,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [RD_PORTS-1:0][$clog2(ENTRIES)-1:0]   rd_idx_i,
    output entry_t [RD_PORTS-1:0]                      rd_data_o,
    input  logic                                       wr_en_i,
    input  logic [$clog2(ENTRIES)-1:0]                 wr_idx_i,
    input  entry_t                                     wr_data_i
);

    entry_t mem [ENTRIES];

    // all entries back to RESET_VAL on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // async read, lane 0 usually serves the fetch lookup
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_data_o[p] = mem[rd_idx_i[p]];
        end
    end

endmodule

// ==== hdl/return_stack.sv ====
`timescale 1ns/1ps

module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  bpu_pkg::ex_feedback_t    fb_i,
    input  bpu_pkg::ras_push_t       push_i,
    input  logic                     ex_stall_i,
    input  logic                     id_stall_i,
    output logic [bpu_pkg::XLEN-1:0] top_o,
    output logic                     empty_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0]      stack_q [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] sp_q;          // entry count, next free slot
    logic [RAS_PTR_W-1:0] sp_after_pop;
    logic [RAS_PTR_W-1:0] top_idx;
    logic                 do_pop;
    logic                 do_push;

    assign empty_o = (sp_q == '0);

    // resolved taken return pops
    assign do_pop = fb_i.valid && fb_i.taken && is_return(fb_i.inst) &&
                    !ex_stall_i && !empty_o;

    assign sp_after_pop = do_pop ? sp_q - 1'b1 : sp_q;

    // push lands after the pop, full stack drops it
    assign do_push = push_i.valid && !ex_stall_i && !id_stall_i &&
                     (sp_after_pop < RAS_PTR_W'(RAS_DEPTH));

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_after_pop[RAS_IDX_W-1:0]] <= push_i.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_pop || do_push) begin
            sp_q <= sp_after_pop + RAS_PTR_W'(do_push);
        end
    end

    // meaningless while empty, consumer looks at empty_o
    assign top_idx = sp_q - 1'b1;
    assign top_o   = stack_q[top_idx[RAS_IDX_W-1:0]];

endmodule

// ==== hdl/tage_predictor.sv ====
`timescale 1ns/1ps

module tage_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  bpu_pkg::ex_feedback_t      fb_i,
    output logic                       taken_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    function automatic logic [TAGGED_IDX_W-1:0] t0_index(input logic [XLEN-1:0] pc,
                                                         input logic [HIST_W-1:0] hist);
        return pc[7:0] ^ hist[7:0];
    endfunction

    function automatic logic [TAGGED_IDX_W-1:0] t1_index(input logic [XLEN-1:0] pc,
                                                         input logic [HIST_W-1:0] hist);
        return pc[7:0] ^ hist[15:8];
    endfunction

    function automatic logic [TAG_W-1:0] t0_tag(input logic [XLEN-1:0] pc,
                                               input logic [HIST_W-1:0] hist);
        return pc[17:8] ^ hist[15:6];
    endfunction

    function automatic logic [TAG_W-1:0] t1_tag(input logic [XLEN-1:0] pc,
                                               input logic [HIST_W-1:0] hist);
        return pc[17:8] ^ {2'b00, hist[7:0]};
    endfunction

    function automatic ctr_t ctr_sat(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    logic [HIST_W-1:0]                    hist_q;
    logic [1:0][BIMODAL_IDX_W-1:0]        bm_idx;   // lane 0 fetch, lane 1 feedback
    logic [1:0][TAGGED_IDX_W-1:0]         t0_idx;
    logic [1:0][TAGGED_IDX_W-1:0]         t1_idx;
    ctr_t [1:0]                           bm_rd;
    tagged_entry_t [1:0]                  t0_rd;
    tagged_entry_t [1:0]                  t1_rd;
    logic [TAG_W-1:0]                     t0_if_tag, t1_if_tag;
    logic [TAG_W-1:0]                     t0_fb_tag, t1_fb_tag;
    logic                                 t0_hit, t1_hit;
    logic                                 t0_we, t1_we;
    tagged_entry_t                        t0_wdata, t1_wdata;

    assign bm_idx[0] = if_pc_i[9:1];
    assign bm_idx[1] = fb_i.pc[9:1];
    assign t0_idx[0] = t0_index(if_pc_i, hist_q);
    assign t0_idx[1] = t0_index(fb_i.pc, fb_i.history);
    assign t1_idx[0] = t1_index(if_pc_i, hist_q);
    assign t1_idx[1] = t1_index(fb_i.pc, fb_i.history);

    assign t0_if_tag = t0_tag(if_pc_i, hist_q);
    assign t1_if_tag = t1_tag(if_pc_i, hist_q);
    assign t0_fb_tag = t0_tag(fb_i.pc, fb_i.history);
    assign t1_fb_tag = t1_tag(fb_i.pc, fb_i.history);

    pred_table #(.entry_t(ctr_t), .ENTRIES(BIMODAL_ENTRIES), .RD_PORTS(2),
                 .RESET_VAL(CTR_WEAK_NT)) u_bimodal (
        .clk, .rst, .rd_idx_i(bm_idx), .rd_data_o(bm_rd),
        .wr_en_i(fb_i.valid), .wr_idx_i(bm_idx[1]),
        .wr_data_i(ctr_sat(bm_rd[1], fb_i.taken))   // bimodal always trains
    );

    pred_table #(.entry_t(tagged_entry_t), .ENTRIES(TAGGED_ENTRIES), .RD_PORTS(2),
                 .RESET_VAL(TAGGED_RESET)) u_t0 (
        .clk, .rst, .rd_idx_i(t0_idx), .rd_data_o(t0_rd),
        .wr_en_i(t0_we), .wr_idx_i(t0_idx[1]), .wr_data_i(t0_wdata)
    );

    pred_table #(.entry_t(tagged_entry_t), .ENTRIES(TAGGED_ENTRIES), .RD_PORTS(2),
                 .RESET_VAL(TAGGED_RESET)) u_t1 (
        .clk, .rst, .rd_idx_i(t1_idx), .rd_data_o(t1_rd),
        .wr_en_i(t1_we), .wr_idx_i(t1_idx[1]), .wr_data_i(t1_wdata)
    );

    // partial tag match, longer history wins
    assign t0_hit = t0_rd[0].tag[TAG_W-1 -: PARTIAL_TAG_BITS] ==
                    t0_if_tag[TAG_W-1 -: PARTIAL_TAG_BITS];
    assign t1_hit = t1_rd[0].tag[TAG_W-1 -: PARTIAL_TAG_BITS] ==
                    t1_if_tag[TAG_W-1 -: PARTIAL_TAG_BITS];

    assign provider_o = t1_hit ? PROV_T1 : (t0_hit ? PROV_T0 : PROV_BIMODAL);
    assign taken_o    = t1_hit ? t1_rd[0].ctr[1] : (t0_hit ? t0_rd[0].ctr[1] : bm_rd[0][1]);

    always_comb begin
        t0_we    = 1'b0;
        t1_we    = 1'b0;
        t0_wdata = t0_rd[1];
        t1_wdata = t1_rd[1];
        if (fb_i.valid && fb_i.pred_correct) begin
            if (fb_i.provider == PROV_T1) begin
                t1_we        = 1'b1;
                t1_wdata.ctr = ctr_sat(t1_rd[1].ctr, fb_i.taken);
            end else if (fb_i.provider == PROV_T0) begin
                t0_we        = 1'b1;
                t0_wdata.ctr = ctr_sat(t0_rd[1].ctr, fb_i.taken);
            end
        end else if (fb_i.valid) begin
            if (fb_i.provider == PROV_T1) begin
                t1_we        = 1'b1;
                t1_wdata.ctr = fb_i.taken ? 2'd3 : 2'd0;   // jump to strong
            end else if (fb_i.provider == PROV_T0) begin
                t0_we        = 1'b1;
                t0_wdata.ctr = fb_i.taken ? 2'd3 : 2'd0;
            end else if (t1_rd[1].tag != t1_fb_tag) begin
                t1_we    = 1'b1;   // allocate on a bimodal miss, T1 first
                t1_wdata = '{tag: t1_fb_tag, ctr: fb_i.taken ? 2'd2 : 2'd1};
            end else begin
                t0_we    = 1'b1;
                t0_wdata = '{tag: t0_fb_tag, ctr: fb_i.taken ? 2'd2 : 2'd1};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (fb_i.valid) begin
            hist_q <= {hist_q[HIST_W-2:0], fb_i.taken};
        end
    end

    assign history_o = hist_q;

endmodule

// ==== sim/bpu_assertions.sv ====
`timescale 1ns/1ps

module bpu_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic [bpu_pkg::RAS_PTR_W-1:0] ras_count_i,
    input bpu_pkg::prediction_t          pred_i,
    input logic [bpu_pkg::HIST_W-1:0]    history_i
);
    import bpu_pkg::*;

    int errors = 0;   // read by the testbench at the end

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        ras_count_i <= RAS_PTR_W'(RAS_DEPTH))
    else begin
        errors++;
        $error("return stack count %0d above depth", ras_count_i);
    end

    taken_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_i.taken |-> pred_i.is_ctrl)
    else begin
        errors++;
        $error("taken prediction for a non-control instruction");
    end

    // first edge after reset release
    history_cleared: assert property (@(posedge clk) $fell(rst) |-> history_i == '0)
    else begin
        errors++;
        $error("history not zero after reset");
    end

endmodule

// stack count taken from the return stack inside the top level
bind bpu_top bpu_assertions u_top_assert (
    .clk, .rst, .ras_count_i(u_ras.sp_q), .pred_i(pred_o), .history_i(history_o)
);

// ==== sim/tb_bpu.sv ====
`timescale 1ns/1ps

module tb_bpu;
    import bpu_pkg::*;

    typedef enum {K_ALU, K_BR, K_JAL, K_JALR, K_RET} kind_e;

    localparam int          MAX_CYCLES = 2000;   // tests run about 55 cycles with reset
    localparam logic [31:0] SEED       = 32'h39ab868b;
    localparam logic [31:0] OFF_B      = 32'hffff_ff40;   // -192
    localparam logic [31:0] OFF_J      = 32'h0001_2344;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   if_pc_i;
    logic [XLEN-1:0]   if_inst_i;
    ex_feedback_t      ex_fb_i;
    ras_push_t         id_push_i;
    logic              ex_stall_i;
    logic              id_stall_i;
    prediction_t       pred_o;
    logic [HIST_W-1:0] history_o;

    // values for the next edge
    logic [XLEN-1:0]   pc_n;
    logic [XLEN-1:0]   inst_n;
    ex_feedback_t      fb_n;
    ras_push_t         push_n;
    logic              ex_stall_n;
    logic              id_stall_n;
    kind_e             fb_kind_n;
    kind_e             fb_kind;   // kind of the feedback on ex_fb_i

    // reference model state
    logic [HIST_W-1:0] hist_m;
    ctr_t              bm_m [int];
    tagged_entry_t     t0_m [int];
    tagged_entry_t     t1_m [int];
    btb_entry_t        btb_m [int];
    logic [XLEN-1:0]   ras_m [$];

    int cycles = 0;
    int n_mismatch = 0;
    int n_other = 0;

    tb_clock u_clk (.clk_o(clk), .rst_o(rst));

    bpu_top dut (
        .clk, .rst, .if_pc_i, .if_inst_i, .ex_fb_i, .id_push_i,
        .ex_stall_i, .id_stall_i, .pred_o, .history_o
    );

    function automatic logic [31:0] encode(input kind_e k, input logic [31:0] off);
        case (k)
            K_BR:    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
            K_JAL:   return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
            K_JALR:  return {12'd0, 5'd6, 3'b000, 5'd1, OPC_JALR};   // jalr x1, 0(x6)
            K_RET:   return {12'd0, 5'd1, 3'b000, 5'd0, OPC_JALR};   // jalr x0, 0(x1)
            default: return 32'h0010_8093;                           // addi x1, x1, 1
        endcase
    endfunction

    function automatic int tagged_idx(input logic [31:0] pc, input logic [HIST_W-1:0] h,
                                      input bit t1);
        return t1 ? int'(pc[7:0] ^ h[15:8]) : int'(pc[7:0] ^ h[7:0]);
    endfunction

    function automatic logic [TAG_W-1:0] tagged_tag(input logic [31:0] pc,
                                                    input logic [HIST_W-1:0] h, input bit t1);
        return t1 ? pc[17:8] ^ {2'b00, h[7:0]} : pc[17:8] ^ h[15:6];
    endfunction

    function automatic tagged_entry_t tagged_get(input bit t1, input int idx);
        tagged_entry_t e;
        e = '{tag: '0, ctr: CTR_WEAK_NT};   // untouched entry
        if (t1 && t1_m.exists(idx)) e = t1_m[idx];
        if (!t1 && t0_m.exists(idx)) e = t0_m[idx];
        return e;
    endfunction

    function automatic ctr_t sat_step(input ctr_t c, input logic up);
        int v;
        v = int'(c) + (up ? 1 : -1);
        if (v > 3) v = 3;
        if (v < 0) v = 0;
        return ctr_t'(v);
    endfunction

    function automatic prediction_t model_predict(input logic [31:0] pc, input kind_e k,
                                                  input logic [31:0] off);
        prediction_t      p;
        tagged_entry_t    e0, e1;
        logic [TAG_W-1:0] g0, g1;
        logic             dir;
        logic             hit;
        logic [31:0]      btb_tgt;
        int               bi;
        e0 = tagged_get(1'b0, tagged_idx(pc, hist_m, 1'b0));
        e1 = tagged_get(1'b1, tagged_idx(pc, hist_m, 1'b1));
        g0 = tagged_tag(pc, hist_m, 1'b0);
        g1 = tagged_tag(pc, hist_m, 1'b1);
        bi = int'(pc[9:1]);
        dir = bm_m.exists(bi) ? bm_m[bi][1] : CTR_WEAK_NT[1];
        p.provider = PROV_BIMODAL;
        if (e1.tag[TAG_W-1 -: PARTIAL_TAG_BITS] == g1[TAG_W-1 -: PARTIAL_TAG_BITS]) begin
            p.provider = PROV_T1;
            dir        = e1.ctr[1];
        end else if (e0.tag[TAG_W-1 -: PARTIAL_TAG_BITS] == g0[TAG_W-1 -: PARTIAL_TAG_BITS]) begin
            p.provider = PROV_T0;
            dir        = e0.ctr[1];
        end
        bi      = int'(pc[9:2]);
        hit     = btb_m.exists(bi) && btb_m[bi].valid && (btb_m[bi].tag == pc[31:10]);
        btb_tgt = hit ? btb_m[bi].target : '0;
        p.is_ctrl = (k != K_ALU);
        p.taken   = 1'b0;
        p.target  = pc + 32'd4;
        if (k == K_JAL) begin
            p.taken  = 1'b1;
            p.target = hit ? btb_tgt : pc + off;
        end else if (k == K_RET && (id_push_i.valid || ras_m.size() > 0)) begin
            p.taken  = 1'b1;
            p.target = id_push_i.valid ? id_push_i.addr : ras_m[$];
        end else if (k == K_BR && dir) begin
            p.taken  = 1'b1;
            p.target = hit ? btb_tgt : pc + off;
        end
        return p;
    endfunction

    function automatic void train_model(input ex_feedback_t fb);
        int               i0, i1, bi;
        tagged_entry_t    e0, e1;
        logic [TAG_W-1:0] g0, g1;
        bi = int'(fb.pc[9:1]);
        i0 = tagged_idx(fb.pc, fb.history, 1'b0);
        i1 = tagged_idx(fb.pc, fb.history, 1'b1);
        e0 = tagged_get(1'b0, i0);
        e1 = tagged_get(1'b1, i1);
        g0 = tagged_tag(fb.pc, fb.history, 1'b0);
        g1 = tagged_tag(fb.pc, fb.history, 1'b1);
        bm_m[bi] = sat_step(bm_m.exists(bi) ? bm_m[bi] : CTR_WEAK_NT, fb.taken);
        if (fb.pred_correct) begin
            if (fb.provider == PROV_T1) begin
                t1_m[i1] = '{tag: e1.tag, ctr: sat_step(e1.ctr, fb.taken)};
            end
            if (fb.provider == PROV_T0) begin
                t0_m[i0] = '{tag: e0.tag, ctr: sat_step(e0.ctr, fb.taken)};
            end
        end else if (fb.provider == PROV_T1) begin
            t1_m[i1] = '{tag: e1.tag, ctr: fb.taken ? 2'd3 : 2'd0};
        end else if (fb.provider == PROV_T0) begin
            t0_m[i0] = '{tag: e0.tag, ctr: fb.taken ? 2'd3 : 2'd0};
        end else if (e1.tag != g1) begin
            t1_m[i1] = '{tag: g1, ctr: fb.taken ? 2'd2 : 2'd1};
        end else begin
            t0_m[i0] = '{tag: g0, ctr: fb.taken ? 2'd2 : 2'd1};
        end
        hist_m = {hist_m[HIST_W-2:0], fb.taken};
        if (fb.taken) begin
            btb_m[int'(fb.pc[9:2])] = '{valid: 1'b1, tag: fb.pc[31:10], target: fb.target};
        end
    endfunction

    // same edge effect as the dut, pop before push
    function automatic void commit_model();
        if (ex_fb_i.valid) begin
            train_model(ex_fb_i);
            if (ex_fb_i.taken && fb_kind == K_RET && !ex_stall_i && ras_m.size() > 0)
                void'(ras_m.pop_back());
        end
        if (id_push_i.valid && !ex_stall_i && !id_stall_i && ras_m.size() < RAS_DEPTH)
            ras_m.push_back(id_push_i.addr);
    endfunction

    task automatic tick();
        @(posedge clk);
        commit_model();
        if_pc_i    <= pc_n;
        if_inst_i  <= inst_n;
        ex_fb_i    <= fb_n;
        id_push_i  <= push_n;
        ex_stall_i <= ex_stall_n;
        id_stall_i <= id_stall_n;
        fb_kind      = fb_kind_n;
        fb_n.valid   = 1'b0;   // one cycle strobes
        push_n.valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic compare_pred(input string name, input prediction_t got, input prediction_t exp);
        if ($isunknown(got)) begin
            n_other++;
            $display("%0t ns: %s has unknown bits", $time, name);
        end else if (got !== exp) begin
            n_mismatch++;
            $write("MISMATCH at %0t ns: %s got ctrl=%b taken=%b target=%h prov=%0d",
                   $time, name, got.is_ctrl, got.taken, got.target, got.provider);
            $display(", expected ctrl=%b taken=%b target=%h prov=%0d",
                     exp.is_ctrl, exp.taken, exp.target, exp.provider);
        end
    endtask

    task automatic compare_hist(input string name, input logic [HIST_W-1:0] got,
                                input logic [HIST_W-1:0] exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fetch(input logic [31:0] pc, input kind_e k, input logic [31:0] off);
        pc_n   = pc;
        inst_n = encode(k, off);
        tick();
        compare_pred("pred_o", pred_o, model_predict(pc, k, off));
    endtask

    task automatic send_fb(input logic [31:0] pc, input kind_e k, input logic taken,
                           input logic correct, input logic [HIST_W-1:0] hist,
                           input logic [31:0] target);
        fb_n = '{valid: 1'b1, taken: taken, pred_correct: correct, pc: pc, history: hist,
                 provider: PROV_BIMODAL, target: target, inst: encode(k, OFF_B)};
        fb_kind_n = k;
        tick();
    endtask

    task automatic push_addr(input logic [31:0] addr);
        push_n = '{valid: 1'b1, addr: addr};
        tick();
    endtask

    // word aligned, pc[17:12] nonzero keeps reset tags from matching
    function automatic logic [31:0] pick_pc();
        logic [31:0] pc;
        do begin
            pc = $urandom() & 32'hffff_fffc;
        end while (pc[17:12] == 6'd0);
        return pc;
    endfunction

    task automatic after_reset_defaults();
        fetch(pick_pc(), K_ALU, '0);
        fetch(pick_pc(), K_BR, OFF_B);
        fetch(pick_pc(), K_JAL, OFF_J);
        fetch(pick_pc(), K_JALR, '0);
        compare_hist("history_o", history_o, '0);
    endtask

    task automatic bimodal_and_btb_fill();
        logic [31:0] pc;
        logic [31:0] far;
        pc  = pick_pc();
        far = pc ^ 32'h0000_4000;   // not reachable by OFF_B
        fetch(pc, K_BR, OFF_B);
        send_fb(pc, K_BR, 1'b1, 1'b1, hist_m, pc + OFF_B);
        send_fb(pc, K_BR, 1'b1, 1'b1, hist_m, pc + OFF_B);
        fetch(pc, K_BR, OFF_B);
        send_fb(pc, K_BR, 1'b1, 1'b1, hist_m, far);
        fetch(pc, K_BR, OFF_B);
        fetch(pc, K_JAL, OFF_J);   // jal at the same pc hits too
    endtask

    task automatic tagged_allocation();
        logic [31:0]       pc;
        logic [HIST_W-1:0] seen;
        pc   = pick_pc();
        seen = {hist_m[HIST_W-2:0], 1'b0};   // history once this outcome is in
        send_fb(pc, K_BR, 1'b0, 1'b0, seen, pc + 32'd4);
        fetch(pc, K_BR, OFF_B);
        compare_hist("history_o", history_o, seen);
    endtask

    task automatic return_stack_order(output logic [31:0] ret_pc);
        ret_pc = pick_pc();
        fetch(ret_pc, K_RET, '0);   // empty
        repeat (3) push_addr(pick_pc());
        fetch(ret_pc, K_RET, '0);
        repeat (2) begin
            send_fb(ret_pc, K_RET, 1'b1, 1'b1, hist_m, ras_m[$]);
            fetch(ret_pc, K_RET, '0);
        end
        id_stall_n = 1'b1;
        push_addr(pick_pc());
        id_stall_n = 1'b0;
        fetch(ret_pc, K_RET, '0);
        ex_stall_n = 1'b1;
        send_fb(ret_pc, K_RET, 1'b1, 1'b1, hist_m, ras_m[$]);   // pop held off by the stall
        ex_stall_n = 1'b0;
        fetch(ret_pc, K_RET, '0);
    endtask

    task automatic same_cycle_bypass(input logic [31:0] ret_pc);
        logic [31:0] first;
        first  = pick_pc();
        push_n = '{valid: 1'b1, addr: first};
        fetch(ret_pc, K_RET, '0);
        push_n = '{valid: 1'b1, addr: pick_pc()};
        send_fb(ret_pc, K_RET, 1'b1, 1'b1, hist_m, first);   // pop and push together
        fetch(ret_pc, K_RET, '0);
        repeat (2) begin
            send_fb(ret_pc, K_RET, 1'b1, 1'b1, hist_m, pc_n);
            fetch(ret_pc, K_RET, '0);   // ends on an empty stack
        end
    endtask

    task automatic history_shift();
        logic t;
        repeat (12) begin
            t = logic'($urandom() % 2);
            send_fb(pick_pc(), K_BR, t, 1'b1, hist_m, 32'h0000_1000);
        end
        tick();
        compare_hist("history_o", history_o, hist_m);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] ret_pc;
        if_pc_i    = '0;
        if_inst_i  = '0;
        ex_fb_i    = '0;
        id_push_i  = '0;
        ex_stall_i = 1'b0;
        id_stall_i = 1'b0;
        pc_n       = '0;
        inst_n     = '0;
        fb_n       = '0;
        push_n     = '0;
        ex_stall_n = 1'b0;
        id_stall_n = 1'b0;
        fb_kind    = K_ALU;
        fb_kind_n  = K_ALU;
        hist_m     = '0;
        void'($urandom(SEED));
        @(negedge rst);
        @(negedge clk);
        after_reset_defaults();
        bimodal_and_btb_fill();
        tagged_allocation();
        return_stack_order(ret_pc);
        same_cycle_bypass(ret_pc);
        history_shift();
        if (dut.u_top_assert.errors > 0) begin
            n_other++;
            $display("a bound assertion failed during the run");
        end
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held from time zero, released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule
